// File: rtl/cp0_pkg.sv
package cp0_pkg;

	// ####################
	// tlb geometry
	// ####################
	localparam int tlb_entries = 8;
	localparam int tlb_index_w = 3;
	localparam int vpn2_w      = 19; // vaddr[31:13]
	localparam int pfn_w       = 20;
	localparam int asid_w      = 8;
	localparam int cattr_w     = 3;  // cache attribute field

	// ####################
	// register numbers
	// ####################
	localparam logic [4:0] reg_index     = 5'd0;
	localparam logic [4:0] reg_entry_lo0 = 5'd2;
	localparam logic [4:0] reg_entry_lo1 = 5'd3;
	localparam logic [4:0] reg_bad_vaddr = 5'd8;
	localparam logic [4:0] reg_count     = 5'd9;
	localparam logic [4:0] reg_entry_hi  = 5'd10;
	localparam logic [4:0] reg_status    = 5'd12;
	localparam logic [4:0] reg_cause     = 5'd13;
	localparam logic [4:0] reg_epc       = 5'd14;
	localparam logic [4:0] reg_error_epc = 5'd30;

	// exception codes
	localparam logic [4:0] excode_int  = 5'd0;
	localparam logic [4:0] excode_adel = 5'd4; // load / fetch address error
	localparam logic [4:0] excode_ades = 5'd5;
	localparam logic [4:0] excode_sys  = 5'd8;

	localparam logic [31:0] status_reset = 32'h1040_0000; // cu0 and bev
	localparam int probe_fail_bit = 31;

	// ####################
	// writable bits
	// ####################
	localparam logic [31:0] mask_index    = 32'h0000_0007;
	localparam logic [31:0] mask_entry_lo = 32'h03ff_ffff;
	localparam logic [31:0] mask_entry_hi = 32'hffff_e0ff;
	localparam logic [31:0] mask_status   = 32'h1040_ff17;
	localparam logic [31:0] mask_cause    = 32'h0000_0300; // software interrupt bits
	localparam logic [31:0] mask_epc      = 32'hffff_ffff;

	// status fields
	localparam int status_erl = 2;
	localparam int status_exl = 1;

	// cause fields
	localparam int cause_bd     = 31;
	localparam int cause_ce_lo  = 28; // two bits
	localparam int cause_ip_lo  = 10; // six hardware lines
	localparam int cause_exc_lo = 2;  // five bits

endpackage

// File: rtl/cp0_regs.sv
module cp0_regs (
	input  logic                             clk,
	input  logic                             rst,
	input  logic [4:0]                       raddr,
	input  logic [2:0]                       rsel,
	input  logic                             we,
	input  logic [4:0]                       waddr,
	input  logic [2:0]                       wsel,
	input  logic [31:0]                      wdata,
	input  logic [5:0]                       int_req,
	input  logic                             tlbr_req,
	input  logic                             tlbp_req,
	input  logic [31:0]                      probe_result,
	input  logic [cp0_pkg::vpn2_w-1:0]       rd_vpn2,
	input  logic [cp0_pkg::asid_w-1:0]       rd_asid,
	input  logic                             rd_g,
	input  logic [cp0_pkg::pfn_w-1:0]        rd_pfn0,
	input  logic [cp0_pkg::cattr_w-1:0]      rd_c0,
	input  logic                             rd_d0,
	input  logic                             rd_v0,
	input  logic [cp0_pkg::pfn_w-1:0]        rd_pfn1,
	input  logic [cp0_pkg::cattr_w-1:0]      rd_c1,
	input  logic                             rd_d1,
	input  logic                             rd_v1,
	input  logic                             except_flush,
	input  logic                             except_eret,
	input  logic                             except_delayslot,
	input  logic [31:0]                      except_pc,
	input  logic [4:0]                       except_code,
	input  logic [31:0]                      except_extra,
	output logic [31:0]                      rdata,
	output logic [31:0]                      entry_hi,
	output logic [31:0]                      entry_lo0,
	output logic [31:0]                      entry_lo1,
	output logic [cp0_pkg::tlb_index_w-1:0]  tlb_index,
	output logic [cp0_pkg::asid_w-1:0]       asid,
	output logic                             user_mode,
	output logic [31:0]                      epc
);
	import cp0_pkg::*;

	logic [31:0] index_r, entry_lo0_r, entry_lo1_r, bad_vaddr_r, count_r;
	logic [31:0] entry_hi_r, status_r, cause_r, epc_r, error_epc_r;
	logic [31:0] index_n, entry_lo0_n, entry_lo1_n, bad_vaddr_n, count_n;
	logic [31:0] entry_hi_n, status_n, cause_n, epc_n, error_epc_n;
	logic [31:0] wmask;

	function automatic logic [31:0] write_mask(input logic [4:0] addr);
		case (addr)
			reg_index:                    write_mask = mask_index;
			reg_entry_lo0, reg_entry_lo1: write_mask = mask_entry_lo;
			reg_entry_hi:                 write_mask = mask_entry_hi;
			reg_status:                   write_mask = mask_status;
			reg_cause:                    write_mask = mask_cause;
			reg_epc, reg_error_epc:       write_mask = mask_epc;
			default:                      write_mask = 32'h0;
		endcase
	endfunction

	function automatic logic [31:0] merge(input logic [31:0] old, din, mask);
		merge = (din & mask) | (old & ~mask);
	endfunction

	assign wmask = write_mask(waddr);

	assign entry_hi  = entry_hi_r;
	assign entry_lo0 = entry_lo0_r;
	assign entry_lo1 = entry_lo1_r;
	assign tlb_index = index_r[tlb_index_w-1:0];
	assign asid      = entry_hi_r[asid_w-1:0];
	assign user_mode = (status_r[4:1] == 4'b1000);
	assign epc       = epc_r;

	// ####################
	// next state
	// ####################
	always_comb
	begin
		index_n     = index_r;
		entry_lo0_n = entry_lo0_r;
		entry_lo1_n = entry_lo1_r;
		bad_vaddr_n = bad_vaddr_r;
		count_n     = count_r + 32'd1;
		entry_hi_n  = entry_hi_r;
		status_n    = status_r;
		cause_n     = cause_r;
		epc_n       = epc_r;
		error_epc_n = error_epc_r;
		cause_n[cause_ip_lo +: 6] = int_req;

		if (we && wsel == 3'd0)
		begin
			case (waddr)
				reg_index:     index_n     = merge(index_n, wdata, wmask);
				reg_entry_lo0: entry_lo0_n = merge(entry_lo0_n, wdata, wmask);
				reg_entry_lo1: entry_lo1_n = merge(entry_lo1_n, wdata, wmask);
				reg_entry_hi:  entry_hi_n  = merge(entry_hi_n, wdata, wmask);
				reg_status:    status_n    = merge(status_n, wdata, wmask);
				reg_cause:     cause_n     = merge(cause_n, wdata, wmask);
				reg_epc:       epc_n       = merge(epc_n, wdata, wmask);
				reg_error_epc: error_epc_n = merge(error_epc_n, wdata, wmask);
				default:       ; // read-only or unimplemented
			endcase
		end

		if (tlbr_req)
		begin
			entry_hi_n[31:13]       = rd_vpn2;
			entry_hi_n[asid_w-1:0]  = rd_asid;
			entry_lo0_n = {6'b0, rd_pfn0, rd_c0, rd_d0, rd_v0, rd_g};
			entry_lo1_n = {6'b0, rd_pfn1, rd_c1, rd_d1, rd_v1, rd_g};
		end

		if (tlbp_req)
			index_n = probe_result;

		if (except_flush)
		begin
			if (except_eret)
			begin
				if (status_n[status_erl])
					status_n[status_erl] = 1'b0;
				else
					status_n[status_exl] = 1'b0;
			end
			else
			begin
				if (!status_n[status_exl]) // nested entry keeps epc
				begin
					epc_n = except_delayslot ? except_pc - 32'd4 : except_pc;
					cause_n[cause_bd] = except_delayslot;
				end
				status_n[status_exl]        = 1'b1;
				cause_n[cause_ce_lo +: 2]   = except_extra[1:0];
				cause_n[cause_exc_lo +: 5]  = except_code;
				if (except_code == excode_adel || except_code == excode_ades)
					bad_vaddr_n = except_extra;
			end
		end
	end

	// reads see this cycle's updates
	always_comb
	begin
		rdata = 32'h0;
		if (rsel == 3'd0)
		begin
			case (raddr)
				reg_index:     rdata = index_n;
				reg_entry_lo0: rdata = entry_lo0_n;
				reg_entry_lo1: rdata = entry_lo1_n;
				reg_bad_vaddr: rdata = bad_vaddr_n;
				reg_count:     rdata = count_n;
				reg_entry_hi:  rdata = entry_hi_n;
				reg_status:    rdata = status_n;
				reg_cause:     rdata = cause_n;
				reg_epc:       rdata = epc_n;
				reg_error_epc: rdata = error_epc_n;
				default:       rdata = 32'h0;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			index_r     <= 32'h0;
			entry_lo0_r <= 32'h0;
			entry_lo1_r <= 32'h0;
			bad_vaddr_r <= 32'h0;
			count_r     <= 32'h0;
			entry_hi_r  <= 32'h0;
			status_r    <= status_reset;
			cause_r     <= 32'h0;
			epc_r       <= 32'h0;
			error_epc_r <= 32'h0;
		end
		else
		begin
			index_r     <= index_n;
			entry_lo0_r <= entry_lo0_n;
			entry_lo1_r <= entry_lo1_n;
			bad_vaddr_r <= bad_vaddr_n;
			count_r     <= count_n;
			entry_hi_r  <= entry_hi_n;
			status_r    <= status_n;
			cause_r     <= cause_n;
			epc_r       <= epc_n;
			error_epc_r <= error_epc_n;
		end
	end

endmodule

// File: rtl/tlb_entry.sv
module tlb_entry (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         we,
	input  logic [cp0_pkg::vpn2_w-1:0]   w_vpn2,
	input  logic [cp0_pkg::asid_w-1:0]   w_asid,
	input  logic                         w_g,
	input  logic [cp0_pkg::pfn_w-1:0]    w_pfn0,
	input  logic [cp0_pkg::cattr_w-1:0]  w_c0,
	input  logic                         w_d0,
	input  logic                         w_v0,
	input  logic [cp0_pkg::pfn_w-1:0]    w_pfn1,
	input  logic [cp0_pkg::cattr_w-1:0]  w_c1,
	input  logic                         w_d1,
	input  logic                         w_v1,
	input  logic [cp0_pkg::vpn2_w-1:0]   probe_vpn2,
	input  logic [cp0_pkg::asid_w-1:0]   probe_asid,
	input  logic [cp0_pkg::vpn2_w-1:0]   lookup_vpn2,
	input  logic [cp0_pkg::asid_w-1:0]   cur_asid,
	output logic [cp0_pkg::vpn2_w-1:0]   vpn2,
	output logic [cp0_pkg::asid_w-1:0]   asid,
	output logic                         g,
	output logic [cp0_pkg::pfn_w-1:0]    pfn0,
	output logic [cp0_pkg::cattr_w-1:0]  c0,
	output logic                         d0,
	output logic                         v0,
	output logic [cp0_pkg::pfn_w-1:0]    pfn1,
	output logic [cp0_pkg::cattr_w-1:0]  c1,
	output logic                         d1,
	output logic                         v1,
	output logic                         probe_hit,
	output logic                         lookup_hit
);

	// valid and global bits
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			g  <= 1'b0;
			v0 <= 1'b0;
			v1 <= 1'b0;
		end
		else if (we)
		begin
			g  <= w_g;
			v0 <= w_v0;
			v1 <= w_v1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (we)
		begin
			vpn2 <= w_vpn2;
			asid <= w_asid;
			pfn0 <= w_pfn0;
			c0   <= w_c0;
			d0   <= w_d0;
			pfn1 <= w_pfn1;
			c1   <= w_c1;
			d1   <= w_d1;
		end
	end

	assign probe_hit  = (vpn2 == probe_vpn2) && (g || asid == probe_asid);
	assign lookup_hit = (vpn2 == lookup_vpn2) && (g || asid == cur_asid);

endmodule

// File: rtl/tlb_write_decode.sv
module tlb_write_decode (
	input  logic                             tlbwi_req,
	input  logic [cp0_pkg::tlb_index_w-1:0]  tlb_index,
	input  logic [31:0]                      entry_hi,
	input  logic [31:0]                      entry_lo0,
	input  logic [31:0]                      entry_lo1,
	output logic [cp0_pkg::tlb_entries-1:0]  entry_we,
	output logic [cp0_pkg::vpn2_w-1:0]       w_vpn2,
	output logic [cp0_pkg::asid_w-1:0]       w_asid,
	output logic                             w_g,
	output logic [cp0_pkg::pfn_w-1:0]        w_pfn0,
	output logic [cp0_pkg::cattr_w-1:0]      w_c0,
	output logic                             w_d0,
	output logic                             w_v0,
	output logic [cp0_pkg::pfn_w-1:0]        w_pfn1,
	output logic [cp0_pkg::cattr_w-1:0]      w_c1,
	output logic                             w_d1,
	output logic                             w_v1
);
	import cp0_pkg::*;

	// one-hot write enable
	always_comb
	begin
		for (int i = 0; i < tlb_entries; i++)
			entry_we[i] = tlbwi_req && (tlb_index == tlb_index_w'(i));
	end

	assign w_vpn2 = entry_hi[31:13];
	assign w_asid = entry_hi[asid_w-1:0];
	assign w_g    = entry_lo0[0] & entry_lo1[0]; // global only if both halves say so

	// entry_lo layout pfn[25:6] c[5:3] d[2] v[1] g[0]
	assign {w_pfn0, w_c0, w_d0, w_v0} = entry_lo0[25:1];
	assign {w_pfn1, w_c1, w_d1, w_v1} = entry_lo1[25:1];

endmodule

// File: rtl/tlb_match_resolve.sv
module tlb_match_resolve (
	input  logic [cp0_pkg::tlb_entries-1:0]                  probe_hits,
	input  logic [cp0_pkg::tlb_entries-1:0]                  lookup_hits,
	input  logic [cp0_pkg::tlb_entries*cp0_pkg::vpn2_w-1:0]  e_vpn2,
	input  logic [cp0_pkg::tlb_entries*cp0_pkg::asid_w-1:0]  e_asid,
	input  logic [cp0_pkg::tlb_entries-1:0]                  e_g,
	input  logic [cp0_pkg::tlb_entries*cp0_pkg::pfn_w-1:0]   e_pfn0,
	input  logic [cp0_pkg::tlb_entries*cp0_pkg::cattr_w-1:0] e_c0,
	input  logic [cp0_pkg::tlb_entries-1:0]                  e_d0,
	input  logic [cp0_pkg::tlb_entries-1:0]                  e_v0,
	input  logic [cp0_pkg::tlb_entries*cp0_pkg::pfn_w-1:0]   e_pfn1,
	input  logic [cp0_pkg::tlb_entries*cp0_pkg::cattr_w-1:0] e_c1,
	input  logic [cp0_pkg::tlb_entries-1:0]                  e_d1,
	input  logic [cp0_pkg::tlb_entries-1:0]                  e_v1,
	input  logic [cp0_pkg::tlb_index_w-1:0]                  tlb_index,
	input  logic [31:0]                                      lookup_vaddr,
	output logic [31:0]                                      probe_result,
	output logic [cp0_pkg::vpn2_w-1:0]                       rd_vpn2,
	output logic [cp0_pkg::asid_w-1:0]                       rd_asid,
	output logic                                             rd_g,
	output logic [cp0_pkg::pfn_w-1:0]                        rd_pfn0,
	output logic [cp0_pkg::cattr_w-1:0]                      rd_c0,
	output logic                                             rd_d0,
	output logic                                             rd_v0,
	output logic [cp0_pkg::pfn_w-1:0]                        rd_pfn1,
	output logic [cp0_pkg::cattr_w-1:0]                      rd_c1,
	output logic                                             rd_d1,
	output logic                                             rd_v1,
	output logic [31:0]                                      lookup_paddr,
	output logic                                             lookup_miss
);
	import cp0_pkg::*;

	logic                   probe_found, lk_found, lk_odd, lk_valid;
	logic [tlb_index_w-1:0] probe_idx, lk_idx;
	logic [pfn_w-1:0]       lk_pfn;

	// lowest index wins, so scan downwards
	always_comb
	begin
		probe_found = 1'b0;
		probe_idx   = '0;
		lk_found    = 1'b0;
		lk_idx      = '0;
		for (int i = tlb_entries - 1; i >= 0; i--)
		begin
			if (probe_hits[i])
			begin
				probe_found = 1'b1;
				probe_idx   = tlb_index_w'(i);
			end
			if (lookup_hits[i])
			begin
				lk_found = 1'b1;
				lk_idx   = tlb_index_w'(i);
			end
		end
	end

	assign probe_result = probe_found ? {{(32 - tlb_index_w){1'b0}}, probe_idx}
		: (32'h1 << probe_fail_bit);

	// ####################
	// tlbr read-back
	// ####################
	assign rd_vpn2 = e_vpn2[tlb_index*vpn2_w +: vpn2_w];
	assign rd_asid = e_asid[tlb_index*asid_w +: asid_w];
	assign rd_g    = e_g[tlb_index];
	assign rd_pfn0 = e_pfn0[tlb_index*pfn_w +: pfn_w];
	assign rd_c0   = e_c0[tlb_index*cattr_w +: cattr_w];
	assign rd_d0   = e_d0[tlb_index];
	assign rd_v0   = e_v0[tlb_index];
	assign rd_pfn1 = e_pfn1[tlb_index*pfn_w +: pfn_w];
	assign rd_c1   = e_c1[tlb_index*cattr_w +: cattr_w];
	assign rd_d1   = e_d1[tlb_index];
	assign rd_v1   = e_v1[tlb_index];

	// lookup translation
	assign lk_odd   = lookup_vaddr[12];
	assign lk_pfn   = lk_odd ? e_pfn1[lk_idx*pfn_w +: pfn_w] : e_pfn0[lk_idx*pfn_w +: pfn_w];
	assign lk_valid = lk_odd ? e_v1[lk_idx] : e_v0[lk_idx];

	assign lookup_paddr = {lk_pfn, lookup_vaddr[11:0]};
	assign lookup_miss  = !lk_found || !lk_valid;

endmodule

// File: rtl/mmu_cp0_top.sv
module mmu_cp0_top (
	input  logic                        clk,
	input  logic                        rst,
	input  logic [4:0]                  raddr,
	input  logic [2:0]                  rsel,
	output logic [31:0]                 rdata,
	input  logic                        we,
	input  logic [4:0]                  waddr,
	input  logic [2:0]                  wsel,
	input  logic [31:0]                 wdata,
	input  logic [5:0]                  int_req,
	input  logic                        tlbr_req,
	input  logic                        tlbp_req,
	input  logic                        tlbwi_req,
	input  logic                        except_flush,
	input  logic                        except_eret,
	input  logic                        except_delayslot,
	input  logic [31:0]                 except_pc,
	input  logic [4:0]                  except_code,
	input  logic [31:0]                 except_extra,
	input  logic [31:0]                 lookup_vaddr,
	output logic [31:0]                 lookup_paddr,
	output logic                        lookup_miss,
	output logic [cp0_pkg::asid_w-1:0]  asid,
	output logic                        user_mode,
	output logic [31:0]                 epc
);
	import cp0_pkg::*;

	logic [31:0]              entry_hi, entry_lo0, entry_lo1, probe_result;
	logic [tlb_index_w-1:0]   tlb_index;
	logic [tlb_entries-1:0]   entry_we, probe_hits, lookup_hits;

	// write fields
	logic [vpn2_w-1:0]  w_vpn2;
	logic [asid_w-1:0]  w_asid;
	logic [pfn_w-1:0]   w_pfn0, w_pfn1;
	logic [cattr_w-1:0] w_c0, w_c1;
	logic               w_g, w_d0, w_v0, w_d1, w_v1;

	// flattened entry array
	logic [tlb_entries*vpn2_w-1:0]  e_vpn2;
	logic [tlb_entries*asid_w-1:0]  e_asid;
	logic [tlb_entries*pfn_w-1:0]   e_pfn0, e_pfn1;
	logic [tlb_entries*cattr_w-1:0] e_c0, e_c1;
	logic [tlb_entries-1:0]         e_g, e_d0, e_v0, e_d1, e_v1;

	// tlbr read-back
	logic [vpn2_w-1:0]  rd_vpn2;
	logic [asid_w-1:0]  rd_asid;
	logic [pfn_w-1:0]   rd_pfn0, rd_pfn1;
	logic [cattr_w-1:0] rd_c0, rd_c1;
	logic               rd_g, rd_d0, rd_v0, rd_d1, rd_v1;

	cp0_regs u_regs (
		.clk, .rst, .raddr, .rsel, .we, .waddr, .wsel, .wdata, .int_req,
		.tlbr_req, .tlbp_req, .probe_result,
		.rd_vpn2, .rd_asid, .rd_g, .rd_pfn0, .rd_c0, .rd_d0, .rd_v0,
		.rd_pfn1, .rd_c1, .rd_d1, .rd_v1,
		.except_flush, .except_eret, .except_delayslot,
		.except_pc, .except_code, .except_extra,
		.rdata, .entry_hi, .entry_lo0, .entry_lo1, .tlb_index,
		.asid, .user_mode, .epc
	);

	tlb_write_decode u_wdec (
		.tlbwi_req, .tlb_index, .entry_hi, .entry_lo0, .entry_lo1, .entry_we,
		.w_vpn2, .w_asid, .w_g, .w_pfn0, .w_c0, .w_d0, .w_v0,
		.w_pfn1, .w_c1, .w_d1, .w_v1
	);

	// ####################
	// entry array
	// ####################
	for (genvar i = 0; i < tlb_entries; i++)
	begin : gen_entry
		tlb_entry u_entry (
			.clk, .rst, .we(entry_we[i]),
			.w_vpn2, .w_asid, .w_g, .w_pfn0, .w_c0, .w_d0, .w_v0,
			.w_pfn1, .w_c1, .w_d1, .w_v1,
			.probe_vpn2(entry_hi[31:13]), .probe_asid(entry_hi[asid_w-1:0]), // probe key
			.lookup_vpn2(lookup_vaddr[31:13]), .cur_asid(asid),
			.vpn2(e_vpn2[i*vpn2_w +: vpn2_w]), .asid(e_asid[i*asid_w +: asid_w]),
			.g(e_g[i]),
			.pfn0(e_pfn0[i*pfn_w +: pfn_w]), .c0(e_c0[i*cattr_w +: cattr_w]),
			.d0(e_d0[i]), .v0(e_v0[i]),
			.pfn1(e_pfn1[i*pfn_w +: pfn_w]), .c1(e_c1[i*cattr_w +: cattr_w]),
			.d1(e_d1[i]), .v1(e_v1[i]),
			.probe_hit(probe_hits[i]), .lookup_hit(lookup_hits[i])
		);
	end

	tlb_match_resolve u_resolve (
		.probe_hits, .lookup_hits,
		.e_vpn2, .e_asid, .e_g, .e_pfn0, .e_c0, .e_d0, .e_v0,
		.e_pfn1, .e_c1, .e_d1, .e_v1,
		.tlb_index, .lookup_vaddr, .probe_result,
		.rd_vpn2, .rd_asid, .rd_g, .rd_pfn0, .rd_c0, .rd_d0, .rd_v0,
		.rd_pfn1, .rd_c1, .rd_d1, .rd_v1,
		.lookup_paddr, .lookup_miss
	);

endmodule

// File: verification/tb_mmu_cp0.sv
module tb_mmu_cp0;
	import cp0_pkg::*;

	logic              clk;
	logic              rst;
	logic [4:0]        raddr;
	logic [2:0]        rsel;
	logic [31:0]       rdata;
	logic              we;
	logic [4:0]        waddr;
	logic [2:0]        wsel;
	logic [31:0]       wdata;
	logic [5:0]        int_req;
	logic              tlbr_req;
	logic              tlbp_req;
	logic              tlbwi_req;
	logic              except_flush;
	logic              except_eret;
	logic              except_delayslot;
	logic [31:0]       except_pc;
	logic [4:0]        except_code;
	logic [31:0]       except_extra;
	logic [31:0]       lookup_vaddr;
	logic [31:0]       lookup_paddr;
	logic              lookup_miss;
	logic [asid_w-1:0] asid;
	logic              user_mode;
	logic [31:0]       epc;

	integer      seed;
	int          errors;
	int          checks;
	logic        lk_chk; // lookup checker enable
	logic [32:0] lk_exp;
	logic [4:0]  reg_list [0:10];

	// reference model state
	logic [31:0] m_reg [0:31];
	logic [31:0] t_hi  [0:tlb_entries-1];
	logic [31:0] t_lo0 [0:tlb_entries-1];
	logic [31:0] t_lo1 [0:tlb_entries-1];

	mmu_cp0_top dut (.*);

	initial
		clk = 1'b0;
	always #10 clk = ~clk;

	// ####################
	// reference functions
	// ####################
	function automatic logic [31:0] writable_bits(input logic [4:0] addr);
		case (addr)
			reg_index:                    return 32'h0000_0007;
			reg_entry_lo0, reg_entry_lo1: return 32'h03ff_ffff;
			reg_entry_hi:                 return 32'hffff_e0ff;
			reg_status:                   return (32'h1 << 28) | (32'h1 << 22) | 32'hff17;
			reg_cause:                    return 32'h0000_0300;
			reg_epc, reg_error_epc:       return 32'hffff_ffff;
			default:                      return 32'h0;
		endcase
	endfunction

	function automatic logic [31:0] masked_write(input logic [31:0] old, din,
			input logic [4:0] addr);
		return (din & writable_bits(addr)) | (old & ~writable_bits(addr));
	endfunction

	function automatic logic [31:0] expected_read(input logic [4:0] addr);
		if (addr == reg_cause)
			return {m_reg[addr][31:16], int_req, m_reg[addr][9:0]}; // live interrupt lines
		return m_reg[addr];
	endfunction

	function automatic logic entry_hits(input int i, input logic [vpn2_w-1:0] vpn2,
			input logic [asid_w-1:0] key_asid);
		logic glob;
		glob = t_lo0[i][0] & t_lo1[i][0];
		return (t_hi[i][31:13] == vpn2) && (glob || t_hi[i][asid_w-1:0] == key_asid);
	endfunction

	function automatic logic [31:0] probe_index(input logic [31:0] key);
		for (int i = 0; i < tlb_entries; i++)
			if (entry_hits(i, key[31:13], key[asid_w-1:0]))
				return 32'(i);
		return 32'h8000_0000;
	endfunction

	// {miss, paddr}
	function automatic logic [32:0] translate(input logic [31:0] va,
			input logic [asid_w-1:0] cur);
		logic [31:0] lo;
		for (int i = 0; i < tlb_entries; i++)
		begin
			if (entry_hits(i, va[31:13], cur))
			begin
				lo = va[12] ? t_lo1[i] : t_lo0[i];
				return {~lo[1], lo[25:6], va[11:0]};
			end
		end
		return {1'b1, 32'h0};
	endfunction

	function automatic int random_below(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	function automatic logic [2:0] nonzero_sel();
		return 3'd1 + 3'(random_below(7));
	endfunction

	// ####################
	// compare tasks
	// ####################
	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic check_asid(input string name, input logic [asid_w-1:0] got,
			input logic [asid_w-1:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[ERROR] %s: got 0x%02h, expected 0x%02h", name, got, exp);
		end
	endtask

	// lookup compare on the rising edge
	always @(posedge clk)
	begin
		if (lk_chk)
		begin
			lk_exp = translate(lookup_vaddr, m_reg[reg_entry_hi][asid_w-1:0]);
			check_bit("lookup_miss", lookup_miss, lk_exp[32]);
			if (!lk_exp[32])
				check_word("lookup_paddr", lookup_paddr, lk_exp[31:0]);
		end
	end

	// ####################
	// drivers
	// ####################
	task automatic write_reg(input logic [4:0] addr, input logic [31:0] data,
			input logic [2:0] sel);
		@(negedge clk);
		we = 1'b1;
		waddr = addr;
		wsel = sel;
		wdata = data;
		if (sel == 3'd0)
			m_reg[addr] = masked_write(m_reg[addr], data, addr);
		@(negedge clk);
		we = 1'b0;
	endtask

	task automatic read_reg(input logic [4:0] addr, input logic [2:0] sel);
		logic [31:0] exp;
		@(negedge clk);
		raddr = addr;
		rsel = sel;
		exp = (sel == 3'd0) ? expected_read(addr) : 32'h0;
		#1;
		check_word($sformatf("rdata[%0d] sel %0d", addr, sel), rdata, exp);
	endtask

	task automatic tlb_command(input int op); // 0 tlbwi, 1 tlbr, 2 tlbp
		int i;
		i = int'(m_reg[reg_index][2:0]);
		@(negedge clk);
		case (op)
			0:
			begin
				tlbwi_req = 1'b1;
				t_hi[i] = m_reg[reg_entry_hi];
				t_lo0[i] = m_reg[reg_entry_lo0];
				t_lo1[i] = m_reg[reg_entry_lo1];
			end
			1:
			begin
				tlbr_req = 1'b1;
				m_reg[reg_entry_hi] = {t_hi[i][31:13], m_reg[reg_entry_hi][12:8],
					t_hi[i][7:0]};
				m_reg[reg_entry_lo0] = {6'b0, t_lo0[i][25:1], t_lo0[i][0] & t_lo1[i][0]};
				m_reg[reg_entry_lo1] = {6'b0, t_lo1[i][25:1], t_lo0[i][0] & t_lo1[i][0]};
			end
			default:
			begin
				tlbp_req = 1'b1;
				m_reg[reg_index] = probe_index(m_reg[reg_entry_hi]);
			end
		endcase
		@(negedge clk);
		tlbwi_req = 1'b0;
		tlbr_req = 1'b0;
		tlbp_req = 1'b0;
	endtask

	task automatic raise_exception(input logic eret, input logic ds, input logic [31:0] pc,
			input logic [4:0] code, input logic [31:0] extra);
		@(negedge clk);
		except_flush = 1'b1;
		except_eret = eret;
		except_delayslot = ds;
		except_pc = pc;
		except_code = code;
		except_extra = extra;
		if (eret)
		begin
			if (m_reg[reg_status][2]) // erl first
				m_reg[reg_status][2] = 1'b0;
			else
				m_reg[reg_status][1] = 1'b0;
		end
		else
		begin
			if (!m_reg[reg_status][1])
			begin
				m_reg[reg_epc] = ds ? pc - 32'd4 : pc;
				m_reg[reg_cause][31] = ds;
			end
			m_reg[reg_status][1] = 1'b1;
			m_reg[reg_cause][29:28] = extra[1:0];
			m_reg[reg_cause][6:2] = code;
			if (code == excode_adel || code == excode_ades)
				m_reg[reg_bad_vaddr] = extra;
		end
		@(negedge clk);
		except_flush = 1'b0;
		except_eret = 1'b0;
	endtask

	task automatic wait_count(input logic [31:0] target);
		int n;
		n = 0;
		@(negedge clk);
		raddr = reg_count;
		rsel = 3'd0;
		#1;
		while (rdata < target && n < 50)
		begin
			@(negedge clk);
			#1;
			n++;
		end
		if (rdata < target)
		begin
			errors++;
			$display("count register did not start counting after reset");
		end
	endtask

	initial
	begin
		#2_000_000;
		$display("timeout: simulation did not finish in time");
		$display("Some tests failed");
		$finish;
	end

	initial
	begin
		logic [31:0] c0;
		logic [31:0] c1;
		logic [31:0] va;
		logic [31:0] hi;
		logic [4:0]  code;
		int          n;
		int          k;
		seed = 32'h5ee2_6f5f;
		errors = 0;
		checks = 0;
		lk_chk = 1'b0;
		rst = 1'b1;
		raddr = 5'd0;
		rsel = 3'd0;
		we = 1'b0;
		waddr = 5'd0;
		wsel = 3'd0;
		wdata = 32'h0;
		int_req = 6'h0;
		tlbr_req = 1'b0;
		tlbp_req = 1'b0;
		tlbwi_req = 1'b0;
		except_flush = 1'b0;
		except_eret = 1'b0;
		except_delayslot = 1'b0;
		except_pc = 32'h0;
		except_code = 5'd0;
		except_extra = 32'h0;
		lookup_vaddr = 32'h0;
		reg_list = '{reg_index, reg_entry_lo0, reg_entry_lo1, reg_bad_vaddr, reg_entry_hi,
			reg_status, reg_cause, reg_epc, reg_error_epc, 5'd1, 5'd16};
		for (int i = 0; i < 32; i++)
			m_reg[i] = 32'h0;
		m_reg[reg_status] = (32'h1 << 28) | (32'h1 << 22); // cu0, bev
		for (int i = 0; i < tlb_entries; i++)
		begin
			t_hi[i] = 32'h0;
			t_lo0[i] = 32'h0;
			t_lo1[i] = 32'h0;
		end
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// ####################
		// reset values
		// ####################
		wait_count(32'd3);
		foreach (reg_list[r])
			read_reg(reg_list[r], 3'd0);
		check_word("epc", epc, 32'h0);
		check_bit("user_mode", user_mode, 1'b0);
		lk_chk = 1'b1;
		repeat (12)
		begin
			@(negedge clk);
			lookup_vaddr = $random(seed);
		end
		@(negedge clk);
		lk_chk = 1'b0;

		// masked writes and ignored selects
		foreach (reg_list[r])
		begin
			repeat (3)
			begin
				write_reg(reg_list[r], $random(seed), 3'd0);
				read_reg(reg_list[r], 3'd0);
			end
			write_reg(reg_list[r], $random(seed), nonzero_sel());
			read_reg(reg_list[r], 3'd0);
			read_reg(reg_list[r], nonzero_sel());
		end
		check_asid("asid", asid, m_reg[reg_entry_hi][asid_w-1:0]);
		check_bit("user_mode", user_mode, m_reg[reg_status][4:1] == 4'b1000);

		@(negedge clk);
		raddr = reg_count;
		rsel = 3'd0;
		#1;
		c0 = rdata;
		n = 5 + random_below(20);
		write_reg(reg_count, $random(seed), 3'd0); // count has no writable bits
		repeat (n - 2) @(negedge clk);
		#1;
		c1 = rdata;
		check_word("count delta", c1 - c0, 32'(n));

		// interrupt lines
		repeat (8)
		begin
			@(negedge clk);
			int_req = 6'($random(seed));
			read_reg(reg_cause, 3'd0);
		end

		// ####################
		// tlb write and lookup
		// ####################
		for (int i = 0; i < tlb_entries; i++)
		begin
			hi = $random(seed);
			hi[7:0] = 8'(random_below(3)); // few asids, so some keys collide
			if (i == 6)
				hi[31:13] = t_hi[1][31:13]; // same page as entry 1
			write_reg(reg_entry_hi, hi, 3'd0);
			write_reg(reg_entry_lo0, $random(seed), 3'd0);
			write_reg(reg_entry_lo1, $random(seed), 3'd0);
			write_reg(reg_index, 32'(i), 3'd0);
			tlb_command(0);
		end
		for (int a = 0; a < 3; a++)
		begin
			hi = $random(seed);
			hi[7:0] = 8'(a);
			write_reg(reg_entry_hi, hi, 3'd0);
			check_asid("asid", asid, m_reg[reg_entry_hi][asid_w-1:0]);
			lk_chk = 1'b1;
			repeat (24)
			begin
				@(negedge clk);
				k = random_below(tlb_entries);
				va = $random(seed);
				if (k != 7)
					va[31:13] = t_hi[k][31:13];
				lookup_vaddr = va;
			end
			@(negedge clk);
			lk_chk = 1'b0;
		end

		// tlbr back into entry_hi / entry_lo
		for (int i = 0; i < tlb_entries; i++)
		begin
			write_reg(reg_index, 32'(i), 3'd0);
			tlb_command(1);
			read_reg(reg_entry_hi, 3'd0);
			read_reg(reg_entry_lo0, 3'd0);
			read_reg(reg_entry_lo1, 3'd0);
		end

		// probe hits and misses
		repeat (24)
		begin
			k = random_below(tlb_entries);
			hi = $random(seed);
			hi[7:0] = 8'(random_below(3));
			if (k != 7)
				hi[31:13] = t_hi[k][31:13];
			write_reg(reg_entry_hi, hi, 3'd0);
			tlb_command(2);
			read_reg(reg_index, 3'd0);
		end

		// ####################
		// exceptions
		// ####################
		write_reg(reg_status, 32'h0000_0014, 3'd0); // um and erl set
		repeat (30)
		begin
			k = random_below(6);
			case (k)
				1:       code = excode_int;
				2:       code = excode_adel;
				3:       code = excode_ades;
				4:       code = excode_sys;
				default: code = 5'($random(seed));
			endcase
			raise_exception(k == 0, 1'($random(seed)), $random(seed) & 32'hffff_fffc,
				code, $random(seed));
			read_reg(reg_epc, 3'd0);
			read_reg(reg_cause, 3'd0);
			read_reg(reg_bad_vaddr, 3'd0);
			read_reg(reg_status, 3'd0);
			check_word("epc", epc, m_reg[reg_epc]);
			check_bit("user_mode", user_mode, m_reg[reg_status][4:1] == 4'b1000);
		end

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// File: src.f
rtl/cp0_pkg.sv
rtl/cp0_regs.sv
rtl/tlb_entry.sv
rtl/tlb_write_decode.sv
rtl/tlb_match_resolve.sv
rtl/mmu_cp0_top.sv
verification/tb_mmu_cp0.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
TOP       := tb_mmu_cp0
FILELIST  := src.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
